/* verilog/pipe_pkg.sv */
// Pipeline package with word types, ALU encodings and stage register layouts
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  alu_a_sel_t;
    typedef logic [1:0]  alu_b_sel_t;
    // Straight from funct3
    typedef logic [2:0]  br_type_t;

    // ALU operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // LUI result is port b unchanged
    localparam alu_op_t ALU_COPY_B = 4'd10;

    // Port a sources
    localparam alu_a_sel_t A_RS1  = 2'd0;
    localparam alu_a_sel_t A_PC   = 2'd1;
    localparam alu_a_sel_t A_ZERO = 2'd2;

    // Port b sources, FOUR builds the link value
    localparam alu_b_sel_t B_RS2   = 2'd0;
    localparam alu_b_sel_t B_IMM_I = 2'd1;
    localparam alu_b_sel_t B_IMM_U = 2'd2;
    localparam alu_b_sel_t B_FOUR  = 2'd3;

    // Decoded control, immediates already sign-extended
    typedef struct packed {
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       reg_write;
        logic       dren;
        logic       dwen;
        logic       branch;
        logic       jal;
        logic       jalr;
        alu_op_t    alu_op;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        br_type_t   br_type;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      imm_u;
        logic       illegal;
    } ctrl_t;

    // Fetch to execute
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_ex_t;

    // Execute to memory/writeback
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_write;
        logic      dren;
        logic      dwen;
        logic      illegal;
        word_t     port_out;
        word_t     store_data;
    } ex_mem_t;

endpackage

/* verilog/decode_unit.sv */
// Instruction decoder from an RV32I word to control fields and immediates
module decode_unit (
    input  pipe_pkg::word_t instr,
    output pipe_pkg::ctrl_t ctrl
);
    import pipe_pkg::*;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    alu_op_t    op_arith;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    // OP and OP-IMM share the funct3 map
    always_comb begin
        case (funct3)
            // No SUBI, bit 30 of an I immediate is just offset
            3'b000:  op_arith = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
            3'b001:  op_arith = ALU_SLL;
            3'b010:  op_arith = ALU_SLT;
            3'b011:  op_arith = ALU_SLTU;
            3'b100:  op_arith = ALU_XOR;
            // SRAI keeps bit 30 set as well
            3'b101:  op_arith = funct7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  op_arith = ALU_OR;
            default: op_arith = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.rd      = instr[11:7];
        ctrl.br_type = funct3;
        ctrl.imm_i   = {{20{instr[31]}}, instr[31:20]};
        ctrl.imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        ctrl.imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        ctrl.imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        ctrl.imm_u   = {instr[31:12], 12'd0};
        ctrl.alu_op    = ALU_ADD;
        ctrl.alu_a_sel = A_RS1;
        ctrl.alu_b_sel = B_IMM_I;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = op_arith;
                ctrl.alu_b_sel = B_RS2;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = op_arith;
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_COPY_B;
                ctrl.alu_a_sel = A_ZERO;
                ctrl.alu_b_sel = B_IMM_U;
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_a_sel = A_PC;
                ctrl.alu_b_sel = B_IMM_U;
            end
            // Jumps compute the link as pc + 4 in the ALU
            OPC_JAL, OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal       = (opcode == OPC_JAL);
                ctrl.jalr      = (opcode == OPC_JALR);
                ctrl.alu_a_sel = A_PC;
                ctrl.alu_b_sel = B_FOUR;
            end
            OPC_BRANCH: ctrl.branch = 1'b1;
            OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.dren      = 1'b1;
            end
            // Address offset swapped to S format in execute
            OPC_STORE: ctrl.dwen = 1'b1;
            // Unknown opcode retires as a no-op
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

/* verilog/reg_file.sv */
// Integer register file, 32 entries, two read ports and one write port
module reg_file (
    input  logic                CLK,
    input  logic                nRST,
    input  pipe_pkg::reg_addr_t rs1,
    input  pipe_pkg::reg_addr_t rs2,
    output pipe_pkg::word_t     rs1_data,
    output pipe_pkg::word_t     rs2_data,
    input  pipe_pkg::reg_addr_t rd,
    input  pipe_pkg::word_t     w_data,
    input  logic                wen
);
    import pipe_pkg::*;

    word_t regs [32];

    // Entry 0 is cleared on reset and never written
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= w_data;
        end
    end

    // No bypass, memory-stage forwarding covers the gap
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 reads as zero whatever was written at it
    assert property (@(posedge CLK) disable iff (!nRST) (rs1 == '0) |-> (rs1_data == '0));

endmodule

/* verilog/fetch_stage.sv */
// Fetch stage holding the PC and the fetch-to-execute register
module fetch_stage #(
    parameter pipe_pkg::word_t RESET_PC = '0
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               stall,
    input  logic               flush,
    input  pipe_pkg::word_t    redirect_pc,
    output pipe_pkg::word_t    imem_addr,
    input  pipe_pkg::word_t    imem_rdata,
    output pipe_pkg::fetch_ex_t fetch_ex
);
    import pipe_pkg::*;

    word_t pc;

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    // Always predict fall-through, execute corrects on redirect
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '0;
        end else if (flush) begin
            // Wrong-path word becomes a bubble
            fetch_ex <= '0;
        end else if (!stall) begin
            fetch_ex.valid <= 1'b1;
            fetch_ex.pc    <= pc;
            fetch_ex.instr <= imem_rdata;
        end
    end

endmodule

/* verilog/execute_stage.sv */
// Execute stage with decode, register read, forwarding, ALU and branch resolution
module execute_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  pipe_pkg::fetch_ex_t fetch_ex,
    input  logic                stall,
    input  logic                flush,
    input  logic                fwd_rs1,
    input  logic                fwd_rs2,
    input  pipe_pkg::word_t     wb_data,
    input  pipe_pkg::reg_addr_t wb_rd,
    input  logic                wb_en,
    output pipe_pkg::reg_addr_t rs1_e,
    output pipe_pkg::reg_addr_t rs2_e,
    output logic                redirect,
    output pipe_pkg::word_t     redirect_pc,
    output pipe_pkg::ex_mem_t   ex_mem
);
    import pipe_pkg::*;

    ctrl_t   ctrl;
    word_t   rs1_data, rs2_data;
    word_t   rs1_fwd, rs2_fwd;
    word_t   port_a, port_b, alu_out;
    logic    br_cond;
    ex_mem_t ex_mem_n;

    decode_unit i_decode (
        .instr (fetch_ex.instr),
        .ctrl  (ctrl)
    );

    // Written from the memory stage
    reg_file i_reg_file (
        .CLK,
        .nRST,
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd       (wb_rd),
        .w_data   (wb_data),
        .wen      (wb_en)
    );

    assign rs1_e = ctrl.rs1;
    assign rs2_e = ctrl.rs2;

    // Memory-stage result wins over the register file
    assign rs1_fwd = fwd_rs1 ? wb_data : rs1_data;
    assign rs2_fwd = fwd_rs2 ? wb_data : rs2_data;

    always_comb begin
        case (ctrl.alu_a_sel)
            A_RS1:   port_a = rs1_fwd;
            A_PC:    port_a = fetch_ex.pc;
            A_ZERO:  port_a = '0;
            default: port_a = '0;
        endcase
        case (ctrl.alu_b_sel)
            B_RS2:   port_b = rs2_fwd;
            // Stores take the split S offset
            B_IMM_I: port_b = ctrl.dwen ? ctrl.imm_s : ctrl.imm_i;
            B_IMM_U: port_b = ctrl.imm_u;
            default: port_b = 32'd4;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_out = port_a - port_b;
            ALU_SLL:    alu_out = port_a << port_b[4:0];
            ALU_SLT:    alu_out = {31'd0, $signed(port_a) < $signed(port_b)};
            ALU_SLTU:   alu_out = {31'd0, port_a < port_b};
            ALU_XOR:    alu_out = port_a ^ port_b;
            ALU_SRL:    alu_out = port_a >> port_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(port_a) >>> port_b[4:0]);
            ALU_OR:     alu_out = port_a | port_b;
            ALU_AND:    alu_out = port_a & port_b;
            ALU_COPY_B: alu_out = port_b;
            default:    alu_out = port_a + port_b;
        endcase
    end

    // Branch condition on forwarded operands
    always_comb begin
        case (ctrl.br_type)
            3'b000:  br_cond = (rs1_fwd == rs2_fwd);
            3'b001:  br_cond = (rs1_fwd != rs2_fwd);
            3'b100:  br_cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
            3'b101:  br_cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            3'b110:  br_cond = (rs1_fwd < rs2_fwd);
            3'b111:  br_cond = (rs1_fwd >= rs2_fwd);
            default: br_cond = 1'b0;
        endcase
    end

    // JALR target drops bit 0
    always_comb begin
        if (ctrl.jalr) begin
            redirect_pc = (rs1_fwd + ctrl.imm_i) & ~32'd1;
        end else if (ctrl.jal) begin
            redirect_pc = fetch_ex.pc + ctrl.imm_j;
        end else begin
            redirect_pc = fetch_ex.pc + ctrl.imm_b;
        end
    end

    assign redirect = fetch_ex.valid && (ctrl.jal || ctrl.jalr || (ctrl.branch && br_cond));

    always_comb begin
        ex_mem_n = '0;
        if (fetch_ex.valid) begin
            ex_mem_n.valid      = 1'b1;
            ex_mem_n.pc         = fetch_ex.pc;
            ex_mem_n.rd         = ctrl.rd;
            ex_mem_n.illegal    = ctrl.illegal;
            // Illegal word keeps no side effects
            ex_mem_n.reg_write  = ctrl.reg_write && !ctrl.illegal;
            ex_mem_n.dren       = ctrl.dren && !ctrl.illegal;
            ex_mem_n.dwen       = ctrl.dwen && !ctrl.illegal;
            ex_mem_n.port_out   = alu_out;
            ex_mem_n.store_data = rs2_fwd;
        end
    end

    // Holds while memory waits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem <= ex_mem_n;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) redirect |-> fetch_ex.valid);

    // Slot behind a taken redirect arrives as a bubble
    assert property (@(posedge CLK) disable iff (!nRST) flush |=> !fetch_ex.valid);

endmodule

/* verilog/mem_stage.sv */
// Memory and writeback stage driving data memory, register write and retirement
module mem_stage (
    input  pipe_pkg::ex_mem_t   ex_mem,
    input  logic                stall,
    output pipe_pkg::word_t     dmem_addr,
    output pipe_pkg::word_t     dmem_wdata,
    output logic                dmem_ren,
    output logic                dmem_wen,
    input  pipe_pkg::word_t     dmem_rdata,
    output pipe_pkg::word_t     wb_data,
    output pipe_pkg::reg_addr_t wb_rd,
    output logic                wb_en,
    output logic                retire_valid,
    output pipe_pkg::word_t     retire_pc,
    output pipe_pkg::reg_addr_t retire_rd,
    output pipe_pkg::word_t     retire_data,
    output logic                retire_illegal
);
    import pipe_pkg::*;

    // Strobes stay up through a wait since ex_mem holds
    assign dmem_addr  = ex_mem.port_out;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_ren   = ex_mem.valid && ex_mem.dren;
    assign dmem_wen   = ex_mem.valid && ex_mem.dwen;

    // Load data is valid in this cycle unless waiting
    assign wb_data = ex_mem.dren ? dmem_rdata : ex_mem.port_out;
    assign wb_rd   = ex_mem.rd;
    assign wb_en   = ex_mem.valid && ex_mem.reg_write && !stall;

    // One pulse per instruction
    assign retire_valid   = ex_mem.valid && !stall;
    assign retire_pc      = ex_mem.pc;
    assign retire_rd      = ex_mem.rd;
    assign retire_data    = wb_data;
    assign retire_illegal = ex_mem.valid && ex_mem.illegal;

    // Decoder never marks one word as both load and store
    always_comb begin
        assert (!(dmem_ren && dmem_wen));
    end

endmodule

/* verilog/hazard_unit.sv */
// Hazard unit for forwarding selects, redirect flush and memory-wait stall
module hazard_unit (
    input  pipe_pkg::ex_mem_t   ex_mem,
    input  pipe_pkg::reg_addr_t rs1_e,
    input  pipe_pkg::reg_addr_t rs2_e,
    input  logic                redirect,
    input  logic                dmem_wait,
    output logic                fwd_rs1,
    output logic                fwd_rs2,
    output logic                flush,
    output logic                stall
);
    import pipe_pkg::*;

    logic mem_writes_rd;

    // x0 destinations never forward
    assign mem_writes_rd = ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != '0);

    assign fwd_rs1 = mem_writes_rd && (ex_mem.rd == rs1_e);
    assign fwd_rs2 = mem_writes_rd && (ex_mem.rd == rs2_e);

    // Whole pipe freezes on a waiting access
    assign stall = ex_mem.valid && (ex_mem.dren || ex_mem.dwen) && dmem_wait;

    // Redirect waits for the stall to clear
    assign flush = redirect && !stall;

    always_comb begin
        assert (!(flush && stall));
    end

endmodule

/* verilog/pipe_core.sv */
// Three-stage RV32I pipeline top connecting fetch, execute, memory and hazard logic
module pipe_core #(
    parameter pipe_pkg::word_t RESET_PC = '0
) (
    input  logic                CLK,
    input  logic                nRST,
    output pipe_pkg::word_t     imem_addr,
    input  pipe_pkg::word_t     imem_rdata,
    output pipe_pkg::word_t     dmem_addr,
    output pipe_pkg::word_t     dmem_wdata,
    output logic                dmem_ren,
    output logic                dmem_wen,
    input  pipe_pkg::word_t     dmem_rdata,
    input  logic                dmem_wait,
    output logic                retire_valid,
    output pipe_pkg::word_t     retire_pc,
    output pipe_pkg::reg_addr_t retire_rd,
    output pipe_pkg::word_t     retire_data,
    output logic                retire_illegal
);
    import pipe_pkg::*;

    fetch_ex_t fetch_ex;
    ex_mem_t   ex_mem;
    logic      stall, flush, redirect;
    word_t     redirect_pc;
    reg_addr_t rs1_e, rs2_e;
    logic      fwd_rs1, fwd_rs2;
    word_t     wb_data;
    reg_addr_t wb_rd;
    logic      wb_en;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .CLK,
        .nRST,
        .stall,
        .flush,
        .redirect_pc,
        .imem_addr,
        .imem_rdata,
        .fetch_ex
    );

    execute_stage i_execute (
        .CLK,
        .nRST,
        .fetch_ex,
        .stall,
        .flush,
        .fwd_rs1,
        .fwd_rs2,
        .wb_data,
        .wb_rd,
        .wb_en,
        .rs1_e,
        .rs2_e,
        .redirect,
        .redirect_pc,
        .ex_mem
    );

    mem_stage i_mem (
        .ex_mem,
        .stall,
        .dmem_addr,
        .dmem_wdata,
        .dmem_ren,
        .dmem_wen,
        .dmem_rdata,
        .wb_data,
        .wb_rd,
        .wb_en,
        .retire_valid,
        .retire_pc,
        .retire_rd,
        .retire_data,
        .retire_illegal
    );

    hazard_unit i_hazard (
        .ex_mem,
        .rs1_e,
        .rs2_e,
        .redirect,
        .dmem_wait,
        .fwd_rs1,
        .fwd_rs2,
        .flush,
        .stall
    );

endmodule

/* dv/pipe_core_tb.sv */
// Testbench running random RV32I programs on the pipeline against an in-order ISA model
module pipe_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pipe_pkg::*;

    localparam word_t RESET_PC     = 32'h0;
    localparam int    PROG_LEN     = 200;
    localparam int    RESET_CYCLES = 10;
    localparam int    NUM_TESTS    = 5;
    // Forward-only programs retire at most PROG_LEN words each
    localparam int    TIMEOUT      = NUM_TESTS * (PROG_LEN * 8 + RESET_CYCLES + 1) + 200;

    // One expected retirement
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      wr;
        word_t     data;
        logic      illegal;
        logic      ld;
        logic      st;
    } retire_t;

    logic      CLK;
    logic      nRST;
    word_t     imem_addr;
    word_t     imem_rdata;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      dmem_ren;
    logic      dmem_wen;
    logic      dmem_wait;
    logic      retire_valid;
    logic      retire_illegal;
    word_t     retire_pc;
    word_t     retire_data;
    reg_addr_t retire_rd;

    // Memories seen by the DUT
    word_t   prog [256];
    word_t   dmem [64];
    // Model state
    word_t   mmem [64];
    word_t   mregs [32];
    retire_t expq [$];

    logic rst_drive;
    logic wait_en;
    int   cycles;
    int   errors;
    int   tests_ok;
    int   tests_bad;

    pipe_core #(
        .RESET_PC (RESET_PC)
    ) i_pipe_core (
        .CLK,
        .nRST,
        .imem_addr,
        .imem_rdata,
        .dmem_addr,
        .dmem_wdata,
        .dmem_ren,
        .dmem_wen,
        .dmem_rdata,
        .dmem_wait,
        .retire_valid,
        .retire_pc,
        .retire_rd,
        .retire_data,
        .retire_illegal
    );

    // Both memories answer in the same cycle
    assign imem_rdata = prog[imem_addr[9:2]];
    // Junk while waiting shows any early use
    assign dmem_rdata = dmem_wait ? 32'hbad0_bad0 : dmem[dmem_addr[7:2]];

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    // Only x0 to x7 for frequent dependencies
    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom % 8);
    endfunction

    // RV32I encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Integer result by funct3 with alt picking SUB or SRA
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'd0, $signed(x) < $signed(y)};
            3'b011:  return {31'd0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic gen_program(input bit use_ctrl, input bit use_mem, input bit use_ill);
        logic [2:0]  br_f3 [6];
        logic [11:0] last_off;
        logic [2:0]  f3;
        logic [6:0]  f7;
        word_t       w;
        int          i;
        int          k;
        int          off;
        br_f3    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        last_off = '0;
        for (i = 0; i < PROG_LEN - 1; i++) begin
            k  = int'($urandom % 16);
            f3 = 3'($urandom % 8);
            // Forward 1 to 4 words and never past the closing self-jump
            off = 1 + int'($urandom % 4);
            if (i + off > PROG_LEN - 1) begin
                off = PROG_LEN - 1 - i;
            end
            if (use_ill && k == 15) begin
                // Custom-0 opcode unknown to the core
                w       = $urandom;
                w[11:7] = rand_reg();
                w[6:0]  = 7'b0001011;
            end else if (use_ctrl && k >= 11) begin
                k = int'($urandom % 3);
                if (k == 0) begin
                    w = enc_b(13'(off * 4), rand_reg(), rand_reg(), br_f3[$urandom % 6]);
                end else if (k == 1) begin
                    w = enc_j(21'(off * 4), rand_reg());
                end else begin
                    // Absolute target from x0 with a stray bit 0 that JALR drops
                    w = enc_i(12'((i + off) * 4 + int'($urandom % 2)), 5'd0, 3'd0,
                              rand_reg(), 7'b1100111);
                end
            end else if (use_mem && k >= 7) begin
                // Same word again one time in three for store then load pairs
                if ($urandom % 3 != 0) begin
                    last_off = {4'd0, 6'($urandom % 64), 2'b00};
                end
                if ($urandom % 2 == 0) begin
                    w = enc_i(last_off, 5'd0, 3'b010, rand_reg(), 7'b0000011);
                end else begin
                    w = enc_s(last_off, rand_reg(), 5'd0, 3'b010);
                end
            end else if (k < 2) begin
                w = enc_u(20'($urandom), rand_reg(),
                          ($urandom % 2 == 0) ? 7'b0110111 : 7'b0010111);
            end else if ($urandom % 2 == 0) begin
                // SUB and SRA only where bit 30 has a meaning
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 0) ? 7'b0100000 : 7'd0;
                w  = enc_r(f7, rand_reg(), rand_reg(), f3, rand_reg());
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                f7 = (f3 == 3'd5 && $urandom % 2 == 0) ? 7'b0100000 : 7'd0;
                w  = enc_i({f7, 5'($urandom)}, rand_reg(), f3, rand_reg(), 7'b0010011);
            end else begin
                w = enc_i(12'($urandom), rand_reg(), f3, rand_reg(), 7'b0010011);
            end
            prog[i] = w;
        end
        prog[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
        // Past the program each slot holds its own address
        for (i = PROG_LEN; i < 256; i++) begin
            prog[i] = word_t'(i * 4);
        end
    endtask

    // In-order run of the whole program with one queue entry per instruction
    task automatic model_run();
        word_t   pc;
        word_t   ins;
        word_t   a;
        word_t   b;
        word_t   nxt;
        word_t   imm_i;
        word_t   imm_s;
        word_t   imm_b;
        word_t   imm_j;
        word_t   addr;
        retire_t r;
        logic    taken;
        logic    done;
        int      i;
        for (i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        expq.delete();
        pc   = RESET_PC;
        done = 1'b0;
        while (!done) begin
            ins   = prog[pc[9:2]];
            a     = mregs[ins[19:15]];
            b     = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            r     = '0;
            r.pc  = pc;
            r.rd  = ins[11:7];
            r.wr  = 1'b1;
            nxt   = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: r.data = alu_ref(ins[14:12], ins[30], a, b);
                7'b0010011: r.data = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101,
                                             a, imm_i);
                7'b0110111: r.data = {ins[31:12], 12'd0};
                7'b0010111: r.data = pc + {ins[31:12], 12'd0};
                7'b1101111: begin
                    r.data = pc + 32'd4;
                    nxt    = pc + imm_j;
                end
                7'b1100111: begin
                    r.data = pc + 32'd4;
                    nxt    = (a + imm_i) & ~32'd1;
                end
                7'b1100011: begin
                    r.wr = 1'b0;
                    case (ins[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        3'b110:  taken = (a < b);
                        3'b111:  taken = (a >= b);
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        nxt = pc + imm_b;
                    end
                end
                7'b0000011: begin
                    r.ld   = 1'b1;
                    addr   = a + imm_i;
                    r.data = mmem[addr[7:2]];
                end
                7'b0100011: begin
                    r.wr = 1'b0;
                    r.st = 1'b1;
                    addr = a + imm_s;
                    mmem[addr[7:2]] = b;
                end
                default: begin
                    // Unknown word leaves every register alone
                    r.wr      = 1'b0;
                    r.illegal = 1'b1;
                end
            endcase
            if (r.wr && r.rd != 5'd0) begin
                mregs[r.rd] = r.data;
            end
            expq.push_back(r);
            // Self-jump closes the program
            done = (nxt == pc);
            pc   = nxt;
        end
    endtask

    // One clock with drive after the edge and checks at the falling edge
    task automatic cycle_step();
        retire_t exp;
        @(posedge CLK);
        #2;
        nRST      = rst_drive;
        // About 3 cycles in 10 wait while an access is present
        dmem_wait = wait_en && (dmem_ren || dmem_wen) && ($urandom % 10 < 3);
        @(negedge CLK);
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Pipeline stopped retiring, cycle limit %0d reached", TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            if (dmem_wait && (dmem_ren || dmem_wen)) begin
                check_bit("retire_valid", 1'b0, retire_valid);
            end
            // Store lands at the edge that ends its memory cycle
            if (dmem_wen && !dmem_wait) begin
                dmem[dmem_addr[7:2]] = dmem_wdata;
            end
            if (retire_valid && expq.size() == 0) begin
                $display("Retirement at pc %h with no instruction left in the model",
                         retire_pc);
                errors++;
            end else if (retire_valid) begin
                exp = expq.pop_front();
                check_word("retire_pc", exp.pc, retire_pc);
                check_bit("retire_illegal", exp.illegal, retire_illegal);
                // Strobes belong to the retiring instruction
                check_bit("dmem_ren", exp.ld, dmem_ren);
                check_bit("dmem_wen", exp.st, dmem_wen);
                if (exp.wr) begin
                    check_reg("retire_rd", exp.rd, retire_rd);
                    check_word("retire_data", exp.data, retire_data);
                end
            end
        end
    endtask

    task automatic run_test(input string name, input bit use_ctrl, input bit use_mem,
                            input bit use_ill, input bit use_wait);
        int err_start;
        int n_exp;
        int j;
        err_start = errors;
        rst_drive = 1'b0;
        wait_en   = 1'b0;
        cycle_step();
        check_bit("retire_valid", 1'b0, retire_valid);
        // New program and data while the core sits in reset
        gen_program(use_ctrl, use_mem, use_ill);
        for (j = 0; j < 64; j++) begin
            dmem[j] = $urandom;
            mmem[j] = dmem[j];
        end
        model_run();
        n_exp = expq.size();
        repeat (RESET_CYCLES - 1) begin
            cycle_step();
            check_bit("retire_valid", 1'b0, retire_valid);
        end
        rst_drive = 1'b1;
        wait_en   = use_wait;
        while (expq.size() > 0) begin
            cycle_step();
        end
        for (j = 0; j < 64; j++) begin
            check_word($sformatf("dmem[%0d]", j), mmem[j], dmem[j]);
        end
        if (errors == err_start) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("Test %s: %0d retirements, %0d errors", name, n_exp, errors - err_start);
    endtask

    initial begin
        int i;
        void'($urandom(32'h4f92));
        nRST      = 1'b0;
        rst_drive = 1'b0;
        dmem_wait = 1'b0;
        wait_en   = 1'b0;
        cycles    = 0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        for (i = 0; i < 256; i++) begin
            prog[i] = word_t'(i * 4);
        end
        for (i = 0; i < 64; i++) begin
            dmem[i] = word_t'(i * 4);
        end
        run_test("arith", 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("control", 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("memory", 1'b0, 1'b1, 1'b0, 1'b0);
        run_test("stall", 1'b1, 1'b1, 1'b0, 1'b1);
        run_test("illegal", 1'b1, 1'b1, 1'b1, 1'b1);
        $display("Tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/pipe_pkg.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/hazard_unit.sv
verilog/pipe_core.sv
dv/pipe_core_tb.sv

/* Makefile */
TOP := pipe_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

# Exit status comes from the grep for the pass line
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
